/* zx_paging_top.f */
hdl/zx_pkg.sv
hdl/resetter.sv
hdl/zsignals.sv
hdl/zports.sv
hdl/pager.sv
hdl/zx_paging_top.sv
bench/zx_paging_sva.sv
bench/zx_paging_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the paging testbench with verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module zx_paging_tb \
	-f zx_paging_top.f -o zx_paging_sim &&
./obj_dir/zx_paging_sim | tee /dev/stderr | grep -x 'Done: no errors' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* bench/zx_paging_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module zx_paging_tb;

	import zx_pkg::*;

	localparam int CYCLE_LIMIT = 6000;
	localparam int RES_CYCLES  = 1 << RST_CNT_SIZE;

	logic        fclk = 1'b0;
	logic        reset;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic [15:0] a;
	logic [7:0]  d_in;
	logic        res;
	page_t       page;
	logic        csrom;
	logic [7:0]  d_out;
	logic        d_ena;
	logic        beep;

	page_t       model_page [NUM_WINDOWS];
	logic [7:0]  model_memconf;
	logic        model_beep;

	logic        mem_chk = 1'b0;
	logic        rd_chk = 1'b0;
	logic        state_chk = 1'b0;
	logic        exp_ena;
	logic [7:0]  exp_data;
	logic [8:0]  map_exp;

	integer      seed;
	logic [31:0] rnd;
	int          errors = 0;
	int          checks = 0;
	int          cmp_errors = 0;
	int          cmp_checks = 0;
	int          tests = 0;
	int          test_base = 0;
	int          cycle_cnt = 0;
	int          wait_cnt;

	zx_paging_top dut_i (
		.fclk   (fclk),
		.reset  (reset),
		.iorq_n (iorq_n),
		.mreq_n (mreq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.a      (a),
		.d_in   (d_in),
		.res    (res),
		.page   (page),
		.csrom  (csrom),
		.d_out  (d_out),
		.d_ena  (d_ena),
		.beep   (beep)
	);

	always #20 fclk = ~fclk;

	always @(posedge fclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	// {csrom, page} while mreq is active
	function automatic logic [8:0] paging_ref(input logic [15:0] addr);
		logic [1:0] win;
		logic       rom;
		win = addr[15:14];
		rom = (win == 2'd0) && !model_memconf[MEMCONF_W0_RAM_BIT];
		return {rom, model_page[win]};
	endfunction

	// {claimed, data} for an IN
	function automatic logic [8:0] readback_ref(input logic [15:0] addr);
		if (addr == {PORT_MEMCONF_HI, PORT_LOW_AF})
			return {1'b1, model_memconf};
		if (addr[7:0] == PORT_LOW_AF && addr[15:8] >= 8'h10 && addr[15:8] <= 8'h13)
			return {1'b1, model_page[addr[9:8]]};
		return 9'd0;
	endfunction

	task automatic update_model(input logic [15:0] addr, input logic [7:0] data, input logic m1);
		if (!m1) begin
			if (addr == {PORT_MEMCONF_HI, PORT_LOW_AF})
				model_memconf = data;
			if (addr[7:0] == PORT_LOW_AF && addr[15:8] >= 8'h10 && addr[15:8] <= 8'h13)
				model_page[addr[9:8]] = data;
			if (addr[7:0] == PORT_BORDER_LOW)
				model_beep = data[BEEP_BIT];
		end
	endtask

	task automatic show_mismatch(input string name, input logic [7:0] exp_v,
		input logic [7:0] act_v);
		$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
	endtask

	always @(negedge fclk) begin
		map_exp = paging_ref(a);
		if (mem_chk || state_chk) begin
			cmp_checks++;
			if (page !== map_exp[7:0]) begin
				show_mismatch("page", map_exp[7:0], page);
				cmp_errors++;
			end
		end
		if (mem_chk) begin
			cmp_checks++;
			if (csrom !== map_exp[8]) begin
				show_mismatch("csrom", {7'd0, map_exp[8]}, {7'd0, csrom});
				cmp_errors++;
			end
		end
		if (state_chk) begin
			cmp_checks++;
			if (beep !== model_beep) begin
				show_mismatch("beep", {7'd0, model_beep}, {7'd0, beep});
				cmp_errors++;
			end
			// no memory cycle runs during a port write
			cmp_checks++;
			if (csrom !== 1'b0) begin
				show_mismatch("csrom", 8'd0, {7'd0, csrom});
				cmp_errors++;
			end
		end
		if (rd_chk) begin
			cmp_checks++;
			if (d_ena !== exp_ena) begin
				show_mismatch("d_ena", {7'd0, exp_ena}, {7'd0, d_ena});
				cmp_errors++;
			end else if (exp_ena && d_out !== exp_data) begin
				show_mismatch("d_out", exp_data, d_out);
				cmp_errors++;
			end
		end
	end

	//////////////////////////////
	// z80 bus cycles
	//////////////////////////////

	task automatic mem_access(input logic [15:0] addr);
		@(posedge fclk);
		a      <= addr;
		mreq_n <= 1'b0;
		rd_n   <= 1'b0;
		// strobes reach the pager two cycles late
		repeat (4) @(posedge fclk);
		mem_chk = 1'b1;
		repeat (4) @(posedge fclk);
		mem_chk = 1'b0;
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		repeat (4) @(posedge fclk);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data, input logic m1);
		@(posedge fclk);
		a      <= addr;
		d_in   <= data;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		m1_n   <= ~m1;
		repeat (8) @(posedge fclk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
		update_model(addr, data, m1);
		state_chk = 1'b1;
		repeat (4) @(posedge fclk);
		state_chk = 1'b0;
	endtask

	task automatic io_read(input logic [15:0] addr);
		@(posedge fclk);
		a      <= addr;
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		{exp_ena, exp_data} = readback_ref(addr);
		// unclaimed ports are watched for the whole cycle
		rd_chk = !exp_ena;
		repeat (4) @(posedge fclk);
		rd_chk = 1'b1;
		repeat (4) @(posedge fclk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		rd_chk = !exp_ena;
		repeat (4) @(posedge fclk);
		rd_chk = 1'b0;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s finished with %0d errors", tests, name,
			errors + cmp_errors - test_base);
		test_base = errors + cmp_errors;
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	initial begin
		seed          = 32'h567c_8697;
		model_page    = XTPAGE_RESET;
		model_memconf = MEMCONF_RESET;
		model_beep    = 1'b0;
		reset  <= 1'b1;
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
		a      <= '0;
		d_in   <= '0;
		repeat (4) @(posedge fclk);
		reset <= 1'b0;
		wait_cnt = 0;
		@(negedge fclk);
		while (res === 1'b1 && wait_cnt < 4 * RES_CYCLES) begin
			wait_cnt++;
			@(negedge fclk);
		end
		checks++;
		if (res !== 1'b0) begin
			$display("internal reset res never fell after the external reset");
			errors++;
		end else begin
			if (wait_cnt != RES_CYCLES) begin
				show_mismatch("res_cycles", RES_CYCLES[7:0], wait_cnt[7:0]);
				errors++;
			end
			for (int w = 0; w < NUM_WINDOWS; w++) begin
				rnd = $random(seed);
				mem_access({w[1:0], rnd[13:0]});
			end
			end_test("reset values");

			for (int w = 0; w < NUM_WINDOWS; w++) begin
				rnd = $random(seed);
				io_write({PORT_XTPAGE_HI[7:2], w[1:0], PORT_LOW_AF}, rnd[7:0], 1'b0);
			end
			for (int w = 0; w < NUM_WINDOWS; w++) begin
				rnd = $random(seed);
				mem_access({w[1:0], rnd[13:0]});
			end
			end_test("page writes");

			// bit 3 maps ram into window 0
			io_write({PORT_MEMCONF_HI, PORT_LOW_AF}, 8'h08, 1'b0);
			mem_access(16'h0100);
			mem_access(16'h4100);
			io_write({PORT_MEMCONF_HI, PORT_LOW_AF}, 8'h00, 1'b0);
			mem_access(16'h0200);
			end_test("memconf");

			for (int w = 0; w < NUM_WINDOWS; w++)
				io_read({PORT_XTPAGE_HI[7:2], w[1:0], PORT_LOW_AF});
			io_read({PORT_MEMCONF_HI, PORT_LOW_AF});
			io_read(16'h22AF);
			io_read(16'h10AE);
			io_read(16'h00FE);
			end_test("read-back");

			io_write(16'h00FE, 8'h10, 1'b0);
			io_write(16'h00FD, 8'h00, 1'b0);
			io_write(16'h7FFE, 8'hEF, 1'b0);
			io_write(16'h34FE, 8'h10, 1'b0);
			// m1 together with iorq is not a port write
			io_write(16'h00FE, 8'h00, 1'b1);
			end_test("beeper");
		end

		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d", tests,
			checks + cmp_checks, errors + cmp_errors, dut_i.sva_i.fail_cnt);
		if (errors + cmp_errors == 0 && dut_i.sva_i.fail_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/zx_paging_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module zx_paging_sva (
	input logic        fclk,
	input logic        res,
	input logic        mreq_n,
	input logic        iord,
	input logic        iowr_s,
	input logic [15:0] a,
	input logic        csrom,
	input logic        d_ena,
	input logic        beep
);

	int   fail_cnt = 0;
	logic read_port;

	// page ports #10AF..#13AF and memconf #21AF
	assign read_port = (a[7:0] == 8'hAF) &&
		(a[15:10] == 6'b000100 || a[15:8] == 8'h21);

	// bus driven only inside a synchronized read of a readable port
	ena_in_read: assert property (@(posedge fclk) d_ena |-> iord && read_port)
	else begin
		fail_cnt++;
		$error("d_ena high outside a read of a page or memconf port");
	end

	// rom cycle follows the raw mreq two cycles late
	rom_in_window0: assert property (@(posedge fclk)
		csrom |-> (a[15:14] == 2'b00) && $past(!mreq_n, 2))
	else begin
		fail_cnt++;
		$error("csrom high outside a window 0 memory cycle");
	end

	// beeper register loads one cycle after the write strobe
	beep_after_write: assert property (@(posedge fclk) disable iff (res)
		!$stable(beep) |-> $past(iowr_s))
	else begin
		fail_cnt++;
		$error("beep changed without a port write");
	end

	quiet_in_reset: assert property (@(posedge fclk) res && $past(res) |-> !d_ena && !beep)
	else begin
		fail_cnt++;
		$error("d_ena or beep high during internal reset");
	end

endmodule

bind zx_paging_top zx_paging_sva sva_i (
	.fclk   (fclk),
	.res    (res),
	.mreq_n (mreq_n),
	.iord   (iord),
	.iowr_s (iowr_s),
	.a      (a),
	.csrom  (csrom),
	.d_ena  (d_ena),
	.beep   (beep)
);

`default_nettype wire

/* hdl/zx_paging_top.sv */
`timescale 1ns/1ps
`default_nettype none

module zx_paging_top (
	// clock and reset
	input  logic                          fclk,
	input  logic                          reset,

	// z80 bus
	input  logic                          iorq_n,
	input  logic                          mreq_n,
	input  logic                          rd_n,
	input  logic                          wr_n,
	input  logic                          m1_n,

	input  logic [zx_pkg::ADDR_WIDTH-1:0] a,
	input  logic [zx_pkg::DATA_WIDTH-1:0] d_in,

	output logic                          res,

	// memory paging
	output zx_pkg::page_t                 page,
	output logic                          csrom,

	// data bus drive
	output logic [zx_pkg::DATA_WIDTH-1:0] d_out,
	output logic                          d_ena,

	output logic                          beep
);

	import zx_pkg::*;

	logic                  mreq;
	logic                  iord;
	logic                  iowr_s;

	page_t                 xt_page [NUM_WINDOWS];
	logic [DATA_WIDTH-1:0] memconf;

	////////////////////////////////
	// reset
	////////////////////////////////

	resetter resetter (
		.fclk  (fclk),
		.reset (reset),
		.rst   (res)
	);

	////////////////////////////////
	// z80 strobes
	////////////////////////////////

	zsignals zsignals (
		.fclk   (fclk),
		.rst    (res),

		.iorq_n (iorq_n),
		.mreq_n (mreq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),

		.mreq   (mreq),
		.iord   (iord),
		.iowr   (),
		.iowr_s (iowr_s)
	);

	////////////////////////////////
	// ports
	////////////////////////////////

	zports zports (
		.fclk    (fclk),
		.rst     (res),

		.a       (a),
		.d_in    (d_in),

		.iord    (iord),
		.iowr_s  (iowr_s),

		.xt_page (xt_page),
		.memconf (memconf),

		.d_out   (d_out),
		.d_ena   (d_ena),

		.beep    (beep)
	);

	////////////////////////////////
	// paging
	////////////////////////////////

	pager pager (
		.a       (a),
		.mreq    (mreq),

		.xt_page (xt_page),
		.memconf (memconf),

		.page    (page),
		.csrom   (csrom)
	);

endmodule

`default_nettype wire

/* hdl/pager.sv */
`timescale 1ns/1ps
`default_nettype none

module pager (
	input  logic [zx_pkg::ADDR_WIDTH-1:0] a,
	input  logic                          mreq,

	input  zx_pkg::page_t                 xt_page [zx_pkg::NUM_WINDOWS],
	input  logic [zx_pkg::DATA_WIDTH-1:0] memconf,

	output zx_pkg::page_t                 page,
	output logic                          csrom
);

	import zx_pkg::*;

	window_t win;
	logic    win0;
	logic    w0_ram;

	////////////////////////////////
	// window select
	////////////////////////////////

	// 16k windows, top two address bits
	assign win  = a[15:14];
	assign win0 = (win == 2'd0);

	// page comes from the window register in all cases,
	// in rom mode it selects the rom bank
	assign page = xt_page[win];

	////////////////////////////////
	// rom select
	////////////////////////////////

	assign w0_ram = memconf[MEMCONF_W0_RAM_BIT];

	assign csrom = mreq & win0 & ~w0_ram;

endmodule

`default_nettype wire

/* hdl/zports.sv */
`timescale 1ns/1ps
`default_nettype none

module zports (
	input  logic                          fclk,
	input  logic                          rst,

	input  logic [zx_pkg::ADDR_WIDTH-1:0] a,
	input  logic [zx_pkg::DATA_WIDTH-1:0] d_in,

	input  logic                          iord,
	input  logic                          iowr_s,

	output zx_pkg::page_t                 xt_page [zx_pkg::NUM_WINDOWS],
	output logic [zx_pkg::DATA_WIDTH-1:0] memconf,

	output logic [zx_pkg::DATA_WIDTH-1:0] d_out,
	output logic                          d_ena,

	output logic                          beep
);

	import zx_pkg::*;

	window_t               xt_sel;

	logic                  hit_xtpage;
	logic                  hit_memconf;
	logic                  hit_border;
	logic                  hit_read;

	logic                  rd_hit;
	logic [DATA_WIDTH-1:0] rd_mux;

	////////////////////////////////
	// address decode
	////////////////////////////////

	// page ports #10AF..#13AF, window number in a[9:8]
	assign xt_sel = a[9:8];

	assign hit_xtpage = (a[7:0] == PORT_LOW_AF) &&
		(a[15:10] == PORT_XTPAGE_HI[7:2]);

	assign hit_memconf = (a == {PORT_MEMCONF_HI, PORT_LOW_AF});

	// #FE answers on any high byte
	assign hit_border = (a[7:0] == PORT_BORDER_LOW);

	// ports that can be read back
	assign hit_read = hit_xtpage | hit_memconf;

	////////////////////////////////
	// registers
	////////////////////////////////

	// address and data are stable for the whole bus cycle
	always_ff @(posedge fclk) begin
		if (rst) begin
			xt_page <= XTPAGE_RESET;
			memconf <= MEMCONF_RESET;
			beep    <= 1'b0;
		end else if (iowr_s) begin
			if (hit_xtpage) begin
				xt_page[xt_sel] <= d_in;
			end

			if (hit_memconf) begin
				memconf <= d_in;
			end

			if (hit_border) begin
				beep <= d_in[BEEP_BIT];
			end
		end
	end

	////////////////////////////////
	// read back
	////////////////////////////////

	always_comb begin
		if (hit_memconf) begin
			rd_mux = memconf;
		end else begin
			rd_mux = xt_page[xt_sel];
		end
	end

	always_ff @(posedge fclk) begin
		d_out <= rd_mux;
	end

	always_ff @(posedge fclk) begin
		if (rst) begin
			rd_hit <= 1'b0;
		end else begin
			rd_hit <= iord & hit_read;
		end
	end

	// released together with iord, no trailing cycle on the bus
	assign d_ena = rd_hit & iord;

endmodule

`default_nettype wire

/* hdl/zsignals.sv */
`timescale 1ns/1ps
`default_nettype none

module zsignals (
	input  logic fclk,
	input  logic rst,

	input  logic iorq_n,
	input  logic mreq_n,
	input  logic rd_n,
	input  logic wr_n,
	input  logic m1_n,

	output logic mreq,
	output logic iord,
	output logic iowr,
	output logic iowr_s
);

	import zx_pkg::*;

	zstrb_t strb_in;
	zstrb_t strb_meta;
	zstrb_t strb_sync;

	logic   iowr_d;

	////////////////////////////////
	// synchronizers
	////////////////////////////////

	assign strb_in.iorq = ~iorq_n;
	assign strb_in.mreq = ~mreq_n;
	assign strb_in.rd   = ~rd_n;
	assign strb_in.wr   = ~wr_n;
	assign strb_in.m1   = ~m1_n;

	// two flops per strobe, cpu bus is asynchronous to fclk
	always_ff @(posedge fclk) begin
		if (rst) begin
			strb_meta <= '0;
			strb_sync <= '0;
		end else begin
			strb_meta <= strb_in;
			strb_sync <= strb_meta;
		end
	end

	////////////////////////////////
	// decoded levels
	////////////////////////////////

	assign mreq = strb_sync.mreq;

	// iorq together with m1 is an interrupt acknowledge
	assign iord = strb_sync.iorq & strb_sync.rd & ~strb_sync.m1;
	assign iowr = strb_sync.iorq & strb_sync.wr & ~strb_sync.m1;

	////////////////////////////////
	// write strobe
	////////////////////////////////

	// one pulse, one cycle after the synchronized rise
	always_ff @(posedge fclk) begin
		if (rst) begin
			iowr_d <= 1'b0;
			iowr_s <= 1'b0;
		end else begin
			iowr_d <= iowr;
			iowr_s <= iowr & ~iowr_d;
		end
	end

endmodule

`default_nettype wire

/* hdl/resetter.sv */
`timescale 1ns/1ps
`default_nettype none

module resetter #(
	parameter int CNT_SIZE = zx_pkg::RST_CNT_SIZE
) (
	input  logic fclk,
	input  logic reset,

	output logic rst
);

	import zx_pkg::*;

	logic [CNT_SIZE-1:0] rst_cnt;
	logic                rst_done;

	// counter restarts on every external reset pulse
	// and runs once to all ones
	always_ff @(posedge fclk) begin
		if (reset) begin
			rst_cnt  <= '0;
			rst_done <= 1'b0;
		end else if (!rst_done) begin
			rst_cnt <= rst_cnt + 1'b1;
			if (&rst_cnt) begin
				rst_done <= 1'b1;
			end
		end
	end

	// held for 2**CNT_SIZE cycles after reset falls
	assign rst = ~rst_done;

endmodule

`default_nettype wire

/* hdl/zx_pkg.sv */
`default_nettype none

package zx_pkg;

	////////////////////////////////
	// bus geometry
	////////////////////////////////

	localparam int ADDR_WIDTH  = 16;
	localparam int DATA_WIDTH  = 8;
	localparam int NUM_WINDOWS = 4;

	// dram page number of one 16k window
	typedef logic [7:0] page_t;

	// cpu window, taken from a[15:14]
	typedef logic [1:0] window_t;

	// z80 strobes after inversion, active high
	typedef struct packed {
		logic iorq;
		logic mreq;
		logic rd;
		logic wr;
		logic m1;
	} zstrb_t;

	////////////////////////////////
	// port map
	////////////////////////////////

	localparam logic [7:0] PORT_LOW_AF     = 8'hAF;
	// #10AF..#13AF select windows 0..3
	localparam logic [7:0] PORT_XTPAGE_HI  = 8'h10;
	localparam logic [7:0] PORT_MEMCONF_HI = 8'h21;
	// border port, low byte only
	localparam logic [7:0] PORT_BORDER_LOW = 8'hFE;

	localparam int BEEP_BIT           = 4;
	localparam int MEMCONF_W0_RAM_BIT = 3;

	////////////////////////////////
	// reset values
	////////////////////////////////

	localparam page_t XTPAGE_RESET [NUM_WINDOWS] = '{8'h00, 8'h05, 8'h02, 8'h00};

	// rom in window 0
	localparam logic [7:0] MEMCONF_RESET = 8'h00;

	localparam int RST_CNT_SIZE = 6;

endpackage

`default_nettype wire
